// ==== verilog.f ====
+incdir+rtl
rtl/gate_pkg.sv
rtl/gate_cfg_regs.sv
rtl/gate_cmd_fifo.sv
rtl/gate_controller.sv
rtl/gate_phase_acc.sv
rtl/gate_sequencer_top.sv
verif/gate_sequencer_chk.sv
verif/gate_sequencer_tb.sv

// ==== verif/gate_sequencer_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "gate_params.svh"

module gate_sequencer_tb
  import gate_pkg::*;
();

  localparam int N_ROWS = 4;

  logic        aclk;
  logic        aresetn;
  logic        wr_en;
  gate_reg_e   wr_addr;
  logic [31:0] wr_data;
  logic        rd_en;
  gate_reg_e   rd_addr;
  wire  [31:0] rd_data;
  wire         sync;
  wire         dout;
  wire  [31:0] phase;

  // Command table, t_on <= t_off <= t_end per row
  logic [31:0] tab_on   [N_ROWS];
  logic [31:0] tab_off  [N_ROWS];
  logic [31:0] tab_end  [N_ROWS];
  logic [31:0] tab_poff [N_ROWS];

  int          limit_cycles = 0;
  int          cyc = 0;
  logic        sync_seen = 1'b0;
  int          sync_cyc [$];
  logic [31:0] sync_phase [$];

  gate_sequencer_top UUT
  (
    .aclk    (aclk),
    .aresetn (aresetn),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .sync    (sync),
    .dout    (dout),
    .phase   (phase)
  );

  initial
  begin
    aclk = 1'b0;
    forever #50 aclk = ~aclk;
  end

  always @(posedge aclk)
    cyc <= cyc + 1;

  // Sync times, and the offset loaded one cycle later
  always @(negedge aclk)
  begin
    if (sync_seen)
      sync_phase.push_back(phase);
    sync_seen = sync;
    if (sync)
      sync_cyc.push_back(cyc);
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reporting and register port

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
    else
      report_failure($sformatf("error: %s expected %h got %h", name, exp, got));
  endtask

  task automatic step_cycle();
    @(posedge aclk);
    @(negedge aclk);
  endtask

  task automatic reg_write(input gate_reg_e addr, input logic [31:0] data);
    wr_en   = 1'b1;
    wr_addr = addr;
    wr_data = data;
    step_cycle();
    wr_en   = 1'b0;
  endtask

  task automatic reg_read_check(input gate_reg_e addr, input logic [31:0] exp,
                                input string name);
    rd_en   = 1'b1;
    rd_addr = addr;
    step_cycle();
    rd_en   = 1'b0;
    check_value(name, rd_data, exp);
  endtask

  // Polls status until it reads the given word
  task automatic wait_for_status(input logic [31:0] exp);
    logic [31:0] st;
    st = ~exp;
    while (st !== exp)
    begin
      rd_en   = 1'b1;
      rd_addr = REG_STATUS;
      step_cycle();
      rd_en   = 1'b0;
      st      = rd_data;
    end
    repeat (2) step_cycle();
  endtask

  task automatic stage_row(input int r);
    reg_write(REG_T_ON, tab_on[r]);
    reg_write(REG_T_OFF, tab_off[r]);
    reg_write(REG_T_END, tab_end[r]);
    reg_write(REG_POFF, tab_poff[r]);
  endtask

  // Offset plus one freq step per open cycle after the sync cycle
  function automatic logic [31:0] expected_phase(input int r, input logic [31:0] f);
    if (tab_on[r] == tab_off[r])
      return tab_poff[r];
    return tab_poff[r] + f * (tab_off[r] - tab_on[r] - 32'd1);
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Test sequences

  task automatic run_single_slot(input int r);
    logic [31:0] f;
    logic        exp_dout;
    int          k;
    f = $urandom();
    reg_write(REG_FREQ, f);
    stage_row(r);
    reg_read_check(REG_T_ON, tab_on[r], "rd_data t_on");
    reg_read_check(REG_T_OFF, tab_off[r], "rd_data t_off");
    reg_read_check(REG_T_END, tab_end[r], "rd_data t_end");
    reg_read_check(REG_POFF, tab_poff[r], "rd_data poff");
    reg_read_check(REG_FREQ, f, "rd_data freq");
    reg_write(REG_PUSH, '0);
    // k counts edges after the push edge
    for (k = 1; k <= tab_end[r] + 3; k++)
    begin
      step_cycle();
      exp_dout = (tab_on[r] != tab_off[r]) && (k >= tab_on[r] + 2) && (k < tab_off[r] + 2);
      check_value("dout", dout, exp_dout);
      check_value("sync", sync, k == tab_on[r] + 2);
      if (k == 2)
      begin
        rd_en   = 1'b1;
        rd_addr = REG_STATUS;
      end
      if (k == 3)
      begin
        rd_en = 1'b0;
        check_value("rd_data status", rd_data, 32'h20);
      end
    end
    check_value("phase", phase, expected_phase(r, f));
  endtask

  task automatic run_back_to_back();
    logic [31:0] f;
    int          r;
    f = $urandom();
    reg_write(REG_FREQ, f);
    sync_cyc.delete();
    sync_phase.delete();
    for (r = 0; r < N_ROWS; r++)
    begin
      stage_row(r);
      reg_write(REG_PUSH, '0);
    end
    wait_for_status(32'h0);
    check_value("sync count", sync_cyc.size(), N_ROWS);
    check_value("sync phase count", sync_phase.size(), N_ROWS);
    for (r = 0; r < N_ROWS; r++)
    begin
      check_value("phase after sync", sync_phase[r], tab_poff[r]);
      // Slot starts are t_end+2 apart, sync sits t_on into each slot
      if (r > 0)
        check_value("sync spacing", sync_cyc[r] - sync_cyc[r-1],
                    int'(tab_end[r-1]) + 2 + int'(tab_on[r]) - int'(tab_on[r-1]));
    end
    check_value("phase", phase, expected_phase(N_ROWS - 1, f));
  endtask

  task automatic run_overflow();
    int n;
    sync_cyc.delete();
    sync_phase.delete();
    reg_write(REG_T_ON, 32'd1);
    reg_write(REG_T_OFF, 32'd3);
    reg_write(REG_T_END, 32'd8);
    reg_write(REG_POFF, 32'h0bad_cafe);
    for (n = 0; n < `GATE_FIFO_DEPTH + 2; n++)
      reg_write(REG_PUSH, '0);
    reg_read_check(REG_STATUS, 32'h30 | `GATE_FIFO_DEPTH, "rd_data status");
    wait_for_status(32'h10);
    check_value("slot count", sync_cyc.size(), `GATE_FIFO_DEPTH + 1);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Main sequence and watchdog

  initial
  begin
    int r;
    int lim;
    void'($urandom(32'h2952ea19));
    tab_on   = '{32'd0, 32'd3, 32'd2, 32'd5};
    tab_off  = '{32'd4, 32'd3, 32'd9, 32'd11};
    tab_end  = '{32'd7, 32'd6, 32'd12, 32'd11};
    tab_poff = '{32'h1000_0000, 32'h2222_0000, 32'h8000_0001, 32'hdead_0000};
    aresetn  = 1'b0;
    wr_en    = 1'b0;
    wr_addr  = REG_T_ON;
    wr_data  = '0;
    rd_en    = 1'b0;
    rd_addr  = REG_T_ON;
    // Two passes over the table, overflow slots, and register traffic
    lim = 600 + (`GATE_FIFO_DEPTH + 1) * 10;
    for (r = 0; r < N_ROWS; r++)
      lim += 2 * (int'(tab_end[r]) + 2);
    limit_cycles = lim;
    repeat (2) @(posedge aclk);
    @(negedge aclk);
    aresetn = 1'b1;
    check_value("dout", dout, 1'b0);
    check_value("sync", sync, 1'b0);
    check_value("phase", phase, 32'h0);
    reg_read_check(REG_STATUS, 32'h0, "rd_data status");
    for (r = 0; r < N_ROWS; r++)
      run_single_slot(r);
    run_back_to_back();
    run_overflow();
    if (UUT.u_ctrl.u_ctrl_chk.fail_cnt + UUT.u_fifo.u_fifo_chk.fail_cnt == 0)
    begin
      $display("All tests passed");
      $finish;
    end
    else
    begin
      report_failure("A bound assertion failed");
    end
  end

  // Bound checker failures end the run when they happen
  initial
  begin
    wait (UUT.u_ctrl.u_ctrl_chk.fail_cnt + UUT.u_fifo.u_fifo_chk.fail_cnt != 0);
    report_failure("A bound assertion failed");
  end

  initial
  begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge aclk);
    report_failure($sformatf("Timeout, tests did not finish in %0d cycles", limit_cycles));
  end

endmodule

`default_nettype wire

// ==== verif/gate_sequencer_chk.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "gate_params.svh"

module gate_sequencer_chk
(
  input wire        aclk,
  input wire        aresetn,
  input wire        sync,
  input wire        dout,
  input wire [31:0] t_on,
  input wire [31:0] t_off,
  input wire        cmd_tready,
  input wire        cmd_tvalid,
  input wire [3:0]  level
);

  // Failed assertions so far
  int fail_cnt = 0;

  a_sync_single: assert property (@(posedge aclk) disable iff (!aresetn) sync |=> !sync)
    else
    begin
      $error("sync stayed high for two cycles");
      fail_cnt++;
    end

  // Gate still open one cycle after sync when the window is wider than one cycle
  a_sync_dout: assert property (@(posedge aclk) disable iff (!aresetn)
    sync && (t_off > t_on + 32'd1) |=> dout)
    else
    begin
      $error("dout low in the cycle after sync");
      fail_cnt++;
    end

  a_ready_valid: assert property (@(posedge aclk) disable iff (!aresetn)
    cmd_tready |-> cmd_tvalid)
    else
    begin
      $error("cmd_tready high while the FIFO is empty");
      fail_cnt++;
    end

  a_level_max: assert property (@(posedge aclk) disable iff (!aresetn)
    level <= 4'(`GATE_FIFO_DEPTH))
    else
    begin
      $error("FIFO level above its depth");
      fail_cnt++;
    end

endmodule

bind gate_controller gate_sequencer_chk u_ctrl_chk
(
  .aclk       (aclk),
  .aresetn    (aresetn),
  .sync       (sync),
  .dout       (dout),
  .t_on       (t_on),
  .t_off      (t_off),
  .cmd_tready (cmd_tready),
  .cmd_tvalid (cmd_tvalid),
  .level      (4'd0)
);

bind gate_cmd_fifo gate_sequencer_chk u_fifo_chk
(
  .aclk       (aclk),
  .aresetn    (aresetn),
  .sync       (1'b0),
  .dout       (1'b0),
  .t_on       (32'd0),
  .t_off      (32'd0),
  .cmd_tready (cmd_tready),
  .cmd_tvalid (cmd_tvalid),
  .level      (level)
);

`default_nettype wire

// ==== rtl/gate_sequencer_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "gate_params.svh"

module gate_sequencer_top
  import gate_pkg::*;
(
  input  wire                      aclk,
  input  wire                      aresetn,
  input  wire                      wr_en,
  input  wire gate_reg_e           wr_addr,
  input  wire [`GATE_FIELD_W-1:0]  wr_data,
  input  wire                      rd_en,
  input  wire gate_reg_e           rd_addr,
  output wire [`GATE_FIELD_W-1:0]  rd_data,
  output wire                      sync,
  output wire                      dout,
  output wire [`GATE_FIELD_W-1:0]  phase
);

  wire                     push;
  wire [`GATE_CMD_W-1:0]   push_cmd;
  wire [`GATE_FIELD_W-1:0] freq;
  wire [3:0]               fifo_level;
  wire                     fifo_overflow;
  wire                     busy;
  wire                     cmd_tvalid;
  wire                     cmd_tready;
  wire [`GATE_CMD_W-1:0]   cmd_tdata;
  wire [`GATE_FIELD_W-1:0] poff;

  gate_cfg_regs u_regs
  (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .wr_en         (wr_en),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .rd_en         (rd_en),
    .rd_addr       (rd_addr),
    .rd_data       (rd_data),
    .push          (push),
    .push_cmd      (push_cmd),
    .freq          (freq),
    .fifo_level    (fifo_level),
    .fifo_overflow (fifo_overflow),
    .busy          (busy)
  );

  gate_cmd_fifo u_fifo
  (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .push       (push),
    .push_cmd   (push_cmd),
    .cmd_tvalid (cmd_tvalid),
    .cmd_tdata  (cmd_tdata),
    .cmd_tready (cmd_tready),
    .level      (fifo_level),
    .overflow   (fifo_overflow)
  );

  gate_controller u_ctrl
  (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .cmd_tready (cmd_tready),
    .cmd_tdata  (cmd_tdata),
    .cmd_tvalid (cmd_tvalid),
    .poff       (poff),
    .sync       (sync),
    .dout       (dout),
    .busy       (busy)
  );

  gate_phase_acc u_acc
  (
    .aclk    (aclk),
    .aresetn (aresetn),
    .sync    (sync),
    .dout    (dout),
    .poff    (poff),
    .freq    (freq),
    .phase   (phase)
  );

endmodule

`default_nettype wire

// ==== rtl/gate_phase_acc.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "gate_params.svh"

module gate_phase_acc
(
  input  wire                      aclk,
  input  wire                      aresetn,
  input  wire                      sync,
  input  wire                      dout,
  input  wire [`GATE_FIELD_W-1:0]  poff,
  input  wire [`GATE_FIELD_W-1:0]  freq,
  output logic [`GATE_FIELD_W-1:0] phase
);

  // Sync edge reloads the offset, open gate steps by freq
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      phase <= '0;
    end
    else if (sync)
    begin
      phase <= poff;
    end
    else if (dout)
    begin
      phase <= phase + freq;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/gate_controller.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "gate_params.svh"

module gate_controller
  import gate_pkg::*;
(
  input  wire                      aclk,
  input  wire                      aresetn,
  output logic                     cmd_tready,
  input  wire [`GATE_CMD_W-1:0]    cmd_tdata,
  input  wire                      cmd_tvalid,
  output logic [`GATE_FIELD_W-1:0] poff,
  output logic                     sync,
  output logic                     dout,
  output logic                     busy
);

  gate_state_e              state_q, state_d;
  logic                     tready_q, tready_d;
  logic                     sync_q, sync_d;
  logic                     dout_q, dout_d;
  logic [`GATE_FIELD_W-1:0] cntr_q, cntr_d;
  logic [`GATE_CMD_W-1:0]   cmd_q, cmd_d;

  logic [`GATE_FIELD_W-1:0] t_on;
  logic [`GATE_FIELD_W-1:0] t_off;
  logic [`GATE_FIELD_W-1:0] t_end;

  assign t_on  = cmd_q[`GATE_T_ON_LSB  +: `GATE_FIELD_W];
  assign t_off = cmd_q[`GATE_T_OFF_LSB +: `GATE_FIELD_W];
  assign t_end = cmd_q[`GATE_T_END_LSB +: `GATE_FIELD_W];

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      state_q  <= GATE_IDLE;
      tready_q <= 1'b0;
      sync_q   <= 1'b0;
      dout_q   <= 1'b0;
      cntr_q   <= '0;
      cmd_q    <= '0;
    end
    else
    begin
      state_q  <= state_d;
      tready_q <= tready_d;
      sync_q   <= sync_d;
      dout_q   <= dout_d;
      cntr_q   <= cntr_d;
      cmd_q    <= cmd_d;
    end
  end

  always_comb
  begin
    state_d  = state_q;
    tready_d = tready_q;
    sync_d   = sync_q;
    dout_d   = dout_q;
    cntr_d   = cntr_q;
    cmd_d    = cmd_q;

    // Sync drops after one cycle, also when the slot ends with it
    if (sync_q)
      sync_d = 1'b0;

    // Capture now, acknowledge on the next cycle
    if (state_q == GATE_IDLE && cmd_tvalid)
    begin
      state_d  = GATE_RUN;
      tready_d = 1'b1;
      cntr_d   = '0;
      cmd_d    = cmd_tdata;
    end

    if (state_q == GATE_RUN)
    begin
      cntr_d = cntr_q + 1'b1;
      if (cntr_q == t_on)
      begin
        sync_d = 1'b1;
        dout_d = 1'b1;
      end
      // Later compare wins when t_on equals t_off
      if (cntr_q == t_off)
        dout_d = 1'b0;
      if (cntr_q == t_end)
        state_d = GATE_IDLE;
      if (tready_q)
        tready_d = 1'b0;
    end
  end

  assign cmd_tready = tready_q;
  assign poff       = cmd_q[`GATE_POFF_LSB +: `GATE_FIELD_W];
  assign sync       = sync_q;
  assign dout       = dout_q;
  assign busy       = (state_q == GATE_RUN);

endmodule

`default_nettype wire

// ==== rtl/gate_cmd_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "gate_params.svh"

module gate_cmd_fifo
(
  input  wire                    aclk,
  input  wire                    aresetn,
  input  wire                    push,
  input  wire [`GATE_CMD_W-1:0]  push_cmd,
  output logic                   cmd_tvalid,
  output logic [`GATE_CMD_W-1:0] cmd_tdata,
  input  wire                    cmd_tready,
  output logic [3:0]             level,
  output logic                   overflow
);

  localparam int PTR_W = $clog2(`GATE_FIFO_DEPTH);

  logic [`GATE_CMD_W-1:0] mem [`GATE_FIFO_DEPTH];
  logic [PTR_W-1:0]       wr_ptr;
  logic [PTR_W-1:0]       rd_ptr;
  logic                   full;
  logic                   wr_ok;
  logic                   rd_ok;

  assign full  = (level == 4'(`GATE_FIFO_DEPTH));
  assign wr_ok = push && !full;
  assign rd_ok = cmd_tvalid && cmd_tready;

  // Head entry stays put until the handshake
  assign cmd_tvalid = (level != 4'd0);
  assign cmd_tdata  = mem[rd_ptr];

  always_ff @(posedge aclk)
  begin
    if (wr_ok)
    begin
      mem[wr_ptr] <= push_cmd;
    end
  end

  // Pointers wrap naturally for a power-of-two depth
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      level    <= 4'd0;
      overflow <= 1'b0;
    end
    else
    begin
      if (wr_ok)
        wr_ptr <= wr_ptr + 1'b1;
      if (rd_ok)
        rd_ptr <= rd_ptr + 1'b1;
      case ({wr_ok, rd_ok})
        2'b10:   level <= level + 4'd1;
        2'b01:   level <= level - 4'd1;
        default: ;
      endcase
      // Sticky until reset
      if (push && full)
        overflow <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/gate_cfg_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "gate_params.svh"

module gate_cfg_regs
  import gate_pkg::*;
(
  input  wire                      aclk,
  input  wire                      aresetn,
  input  wire                      wr_en,
  input  wire gate_reg_e           wr_addr,
  input  wire [`GATE_FIELD_W-1:0]  wr_data,
  input  wire                      rd_en,
  input  wire gate_reg_e           rd_addr,
  output logic [`GATE_FIELD_W-1:0] rd_data,
  output logic                     push,
  output logic [`GATE_CMD_W-1:0]   push_cmd,
  output logic [`GATE_FIELD_W-1:0] freq,
  input  wire [3:0]                fifo_level,
  input  wire                      fifo_overflow,
  input  wire                      busy
);

  logic [`GATE_FIELD_W-1:0] t_on_q;
  logic [`GATE_FIELD_W-1:0] t_off_q;
  logic [`GATE_FIELD_W-1:0] t_end_q;
  logic [`GATE_FIELD_W-1:0] poff_q;
  logic [`GATE_FIELD_W-1:0] status_word;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Write side

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      t_on_q  <= '0;
      t_off_q <= '0;
      t_end_q <= '0;
      poff_q  <= '0;
      freq    <= '0;
    end
    else if (wr_en)
    begin
      case (wr_addr)
        REG_T_ON:  t_on_q  <= wr_data;
        REG_T_OFF: t_off_q <= wr_data;
        REG_T_END: t_end_q <= wr_data;
        REG_POFF:  poff_q  <= wr_data;
        REG_FREQ:  freq    <= wr_data;
        default:   ;
      endcase
    end
  end

  // Commit strobe, FIFO samples it on the same edge
  assign push = wr_en && (wr_addr == REG_PUSH);

  always_comb
  begin
    push_cmd = '0;
    push_cmd[`GATE_T_ON_LSB  +: `GATE_FIELD_W] = t_on_q;
    push_cmd[`GATE_T_OFF_LSB +: `GATE_FIELD_W] = t_off_q;
    push_cmd[`GATE_T_END_LSB +: `GATE_FIELD_W] = t_end_q;
    push_cmd[`GATE_POFF_LSB  +: `GATE_FIELD_W] = poff_q;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Read side

  // Level 3:0, overflow 4, busy 5
  assign status_word = {{(`GATE_FIELD_W-6){1'b0}}, busy, fifo_overflow, fifo_level};

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      rd_data <= '0;
    end
    else if (rd_en)
    begin
      case (rd_addr)
        REG_T_ON:   rd_data <= t_on_q;
        REG_T_OFF:  rd_data <= t_off_q;
        REG_T_END:  rd_data <= t_end_q;
        REG_POFF:   rd_data <= poff_q;
        REG_FREQ:   rd_data <= freq;
        REG_STATUS: rd_data <= status_word;
        default:    rd_data <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/gate_pkg.sv ====
`default_nettype none

package gate_pkg;

  // Slot controller state
  typedef enum logic
  {
    GATE_IDLE = 1'b0,
    GATE_RUN  = 1'b1
  } gate_state_e;

  // Host register map
  typedef enum logic [2:0]
  {
    REG_T_ON   = 3'd0,
    REG_T_OFF  = 3'd1,
    REG_T_END  = 3'd2,
    REG_POFF   = 3'd3,
    REG_PUSH   = 3'd4,
    REG_FREQ   = 3'd5,
    REG_STATUS = 3'd6
  } gate_reg_e;

endpackage

`default_nettype wire

// ==== rtl/gate_params.svh ====
`ifndef GATE_PARAMS_SVH
`define GATE_PARAMS_SVH

// Command word holds four 32-bit fields
`define GATE_CMD_W      128
`define GATE_FIELD_W    32

// Field positions inside a command word
`define GATE_T_ON_LSB   0
`define GATE_T_OFF_LSB  32
`define GATE_T_END_LSB  64
`define GATE_POFF_LSB   96

// Queued commands, must be a power of two
`define GATE_FIFO_DEPTH 4

`endif
